/* Bender.yml */
package:
  name: cpu_regs

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cpu_pkg.sv
      - regfile/status_reg.sv
      - regfile/reg_file.sv
      - source/irq_sequencer.sv
      - source/stack_port.sv
      - source/cpu_regs_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/cpu_regs_chk.sv
      - verif/cpu_regs_tb.sv

/* common/cpu_defines.svh */
/*
 * CPU register subsystem constants
 * Handler addresses, stack page, PSR bit positions and interrupt step count
 */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Handler entry points, BRK shares the IRQ handler
`define NMI_HANDLER 16'hfa00
`define IRQ_HANDLER 16'hfe00

// High address byte of every stack access
`define STACK_PAGE 8'h01

// PSR bit positions
`define PSR_C 0
`define PSR_Z 1
`define PSR_I 2
`define PSR_D 3
`define PSR_B 4
`define PSR_V 6
`define PSR_N 7

// Cycles spent in interrupt entry after acceptance
`define IRQ_STEPS 5

`endif

/* common/cpu_pkg.sv */
/*
 * CPU register subsystem types
 * Command, register view and stack write structs, sequencer states
 */
package cpu_pkg;

  // Execution controller command
  typedef struct packed {
    logic       set_c;
    logic       c;
    logic       set_i;
    logic       i;
    logic       set_v;
    logic       v;
    logic       set_d;
    logic       d;
    logic       set_n;
    logic       n;
    logic       set_z;
    logic       z;
    logic [7:0] data;  // Shared by all register loads
    logic       set_a;
    logic       set_x;
    logic       set_y;
    logic       set_s;
    logic       set_pcl;
    logic       set_pch;
  } ec_cmd_t;

  // Memory controller command
  typedef struct packed {
    logic        fetched;  // PC increment
    logic        pushed;
    logic        pull;
    logic [15:0] pc;
    logic        set_pc;
    logic [7:0]  psr;
    logic        set_psr;
    logic [7:0]  push_data;
  } mc_cmd_t;

  // Interrupt sequencer command
  typedef struct packed {
    logic       set_i;
    logic       set_b;
    logic       set_pcl;
    logic       set_pch;
    logic       pushed;
    logic [7:0] data;
    logic [7:0] push_data;
  } il_cmd_t;

  typedef struct packed {
    logic [15:0] pc;
    logic [7:0]  a;
    logic [7:0]  x;
    logic [7:0]  y;
    logic [7:0]  s;
    logic [7:0]  psr;
  } reg_view_t;

  typedef struct packed {
    logic        valid;
    logic [15:0] addr;
    logic [7:0]  data;
  } stack_wr_t;

  typedef enum logic [2:0] {
    IDLE,
    PUSH_PCH,
    PUSH_PCL,
    PUSH_PSR,
    LOAD_PCL,
    LOAD_PCH
  } irq_state_t;

endpackage

/* regfile/reg_file.sv */
/*
 * Register file
 * PC, A, X, Y and S with per-source priorities, PSR held in status_reg
 */
`timescale 1ns/10ps
`include "cpu_defines.svh"

module reg_file (
  input  logic               clk,
  input  logic               rst_x,
  input  logic               cen_i,
  input  cpu_pkg::ec_cmd_t   ec_i,
  input  cpu_pkg::mc_cmd_t   mc_i,
  input  cpu_pkg::il_cmd_t   il_i,
  output cpu_pkg::reg_view_t regs_o
);

  logic [15:0] pc_q;
  logic [7:0]  a_q;
  logic [7:0]  x_q;
  logic [7:0]  y_q;
  logic [7:0]  s_q;
  logic [7:0]  psr;

  logic        load_pc;
  logic        push;
  logic [7:0]  flag_d;
  logic [7:0]  flag_set;

  // Byte loads from either controller block the PC step and set_pc
  assign load_pc = il_i.set_pcl | il_i.set_pch | ec_i.set_pcl | ec_i.set_pch;
  assign push    = mc_i.pushed | il_i.pushed;

  // Flag sources, lowest priority first
  always_comb begin
    flag_d   = mc_i.psr;
    flag_set = {8{mc_i.set_psr}};

    if (il_i.set_i) begin
      flag_d[`PSR_I]   = 1'b1;
      flag_set[`PSR_I] = 1'b1;
    end
    if (il_i.set_b) begin
      flag_d[`PSR_B]   = 1'b1;
      flag_set[`PSR_B] = 1'b1;
    end

    if (ec_i.set_c) begin
      flag_d[`PSR_C]   = ec_i.c;
      flag_set[`PSR_C] = 1'b1;
    end
    if (ec_i.set_z) begin
      flag_d[`PSR_Z]   = ec_i.z;
      flag_set[`PSR_Z] = 1'b1;
    end
    if (ec_i.set_i) begin
      flag_d[`PSR_I]   = ec_i.i;
      flag_set[`PSR_I] = 1'b1;
    end
    if (ec_i.set_d) begin
      flag_d[`PSR_D]   = ec_i.d;
      flag_set[`PSR_D] = 1'b1;
    end
    if (ec_i.set_v) begin
      flag_d[`PSR_V]   = ec_i.v;
      flag_set[`PSR_V] = 1'b1;
    end
    if (ec_i.set_n) begin
      flag_d[`PSR_N]   = ec_i.n;
      flag_set[`PSR_N] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_x) begin
    if (!rst_x) begin
      pc_q <= 16'h0000;
      a_q  <= 8'h00;
      x_q  <= 8'h00;
      y_q  <= 8'h00;
      s_q  <= 8'h00;
    end else if (cen_i) begin
      if (load_pc) begin
        if (il_i.set_pcl) begin
          pc_q[7:0] <= il_i.data;
        end else if (ec_i.set_pcl) begin
          pc_q[7:0] <= ec_i.data;
        end
        if (il_i.set_pch) begin
          pc_q[15:8] <= il_i.data;
        end else if (ec_i.set_pch) begin
          pc_q[15:8] <= ec_i.data;
        end
      end else if (mc_i.fetched) begin
        pc_q <= pc_q + 16'h0001;  // Wraps at ffff
      end else if (mc_i.set_pc) begin
        pc_q <= mc_i.pc;
      end

      if (ec_i.set_a) begin
        a_q <= ec_i.data;
      end
      if (ec_i.set_x) begin
        x_q <= ec_i.data;
      end
      if (ec_i.set_y) begin
        y_q <= ec_i.data;
      end

      if (ec_i.set_s) begin
        s_q <= ec_i.data;
      end else if (push) begin
        s_q <= s_q - 8'h01;  // One decrement even for a double push
      end else if (mc_i.pull) begin
        s_q <= s_q + 8'h01;
      end
    end
  end

  status_reg status_reg_inst (
    .clk        (clk),
    .rst_x      (rst_x),
    .cen_i      (cen_i),
    .flag_i     (flag_d),
    .flag_set_i (flag_set),
    .psr_o      (psr)
  );

  assign regs_o = '{pc: pc_q, a: a_q, x: x_q, y: y_q, s: s_q, psr: psr};

endmodule

/* regfile/status_reg.sv */
/*
 * Processor status register
 * Seven flags with individual load strobes, bit 5 reads as one
 */
`timescale 1ns/10ps
`include "cpu_defines.svh"

module status_reg (
  input  logic       clk,
  input  logic       rst_x,
  input  logic       cen_i,
  input  logic [7:0] flag_i,
  input  logic [7:0] flag_set_i,
  output logic [7:0] psr_o
);

  // Bits backed by a real flop
  localparam logic [7:0] FLAG_MASK = (8'h01 << `PSR_C) |
                                     (8'h01 << `PSR_Z) |
                                     (8'h01 << `PSR_I) |
                                     (8'h01 << `PSR_D) |
                                     (8'h01 << `PSR_B) |
                                     (8'h01 << `PSR_V) |
                                     (8'h01 << `PSR_N);

  logic [7:0] flags_q;
  logic [7:0] load;

  assign load = flag_set_i & FLAG_MASK;

  always_ff @(posedge clk or negedge rst_x) begin
    if (!rst_x) begin
      flags_q <= 8'h00;
    end else if (cen_i) begin
      // Only strobed flags change
      flags_q <= (flags_q & ~load) | (flag_i & load);
    end
  end

  // Unused position is tied high
  assign psr_o = flags_q | ~FLAG_MASK;

endmodule

/* source/cpu_regs_top.sv */
/*
 * CPU register subsystem top
 * Interrupt sequencer, register file and stack write port
 */
`timescale 1ns/10ps

module cpu_regs_top (
  input  logic               clk,
  input  logic               rst_x,
  input  logic               cen_i,
  input  cpu_pkg::ec_cmd_t   ec_i,
  input  cpu_pkg::mc_cmd_t   mc_i,
  input  logic               nmi_i,
  input  logic               irq_i,
  input  logic               brk_i,
  output cpu_pkg::reg_view_t regs_o,
  output cpu_pkg::stack_wr_t stack_o,
  output logic               irq_busy_o
);

  cpu_pkg::reg_view_t regs;
  cpu_pkg::il_cmd_t   il_cmd;

  irq_sequencer irq_sequencer_inst (
    .clk    (clk),
    .rst_x  (rst_x),
    .cen_i  (cen_i),
    .nmi_i  (nmi_i),
    .irq_i  (irq_i),
    .brk_i  (brk_i),
    .regs_i (regs),
    .il_o   (il_cmd),
    .busy_o (irq_busy_o)
  );

  reg_file reg_file_inst (
    .clk    (clk),
    .rst_x  (rst_x),
    .cen_i  (cen_i),
    .ec_i   (ec_i),
    .mc_i   (mc_i),
    .il_i   (il_cmd),
    .regs_o (regs)
  );

  // Sees S before any decrement of this cycle
  stack_port stack_port_inst (
    .clk     (clk),
    .rst_x   (rst_x),
    .cen_i   (cen_i),
    .il_i    (il_cmd),
    .mc_i    (mc_i),
    .sp_i    (regs.s),
    .stack_o (stack_o)
  );

  assign regs_o = regs;

endmodule

/* source/irq_sequencer.sv */
/*
 * Interrupt entry sequencer
 * Accepts NMI, BRK or IRQ, pushes PC and PSR, sets I and loads the handler
 */
`timescale 1ns/10ps
`include "cpu_defines.svh"

module irq_sequencer (
  input  logic               clk,
  input  logic               rst_x,
  input  logic               cen_i,
  input  logic               nmi_i,
  input  logic               irq_i,
  input  logic               brk_i,
  input  cpu_pkg::reg_view_t regs_i,
  output cpu_pkg::il_cmd_t   il_o,
  output logic               busy_o
);

  cpu_pkg::irq_state_t state_q;
  cpu_pkg::irq_state_t state_d;
  logic                nmi_q;  // Latched request type
  logic                brk_q;
  logic                accept;
  logic [15:0]         handler;
  logic [7:0]          psr_push;

  // IRQ is masked by I, NMI and BRK are not
  assign accept  = (state_q == cpu_pkg::IDLE) &
                   (nmi_i | brk_i | (irq_i & ~regs_i.psr[`PSR_I]));
  assign handler = nmi_q ? `NMI_HANDLER : `IRQ_HANDLER;

  always_comb begin
    psr_push          = regs_i.psr;
    psr_push[`PSR_B]  = brk_q;  // B only in the BRK frame
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      cpu_pkg::IDLE:     if (accept) state_d = cpu_pkg::PUSH_PCH;
      cpu_pkg::PUSH_PCH: state_d = cpu_pkg::PUSH_PCL;
      cpu_pkg::PUSH_PCL: state_d = cpu_pkg::PUSH_PSR;
      cpu_pkg::PUSH_PSR: state_d = cpu_pkg::LOAD_PCL;
      cpu_pkg::LOAD_PCL: state_d = cpu_pkg::LOAD_PCH;
      default:           state_d = cpu_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_x) begin
    if (!rst_x) begin
      state_q <= cpu_pkg::IDLE;
      nmi_q   <= 1'b0;
      brk_q   <= 1'b0;
    end else if (cen_i) begin
      state_q <= state_d;
      if (accept) begin
        nmi_q <= nmi_i;
        brk_q <= ~nmi_i & brk_i;  // NMI outranks BRK
      end
    end
  end

  always_comb begin
    il_o = '0;
    case (state_q)
      cpu_pkg::PUSH_PCH: begin
        il_o.pushed    = 1'b1;
        il_o.push_data = regs_i.pc[15:8];
      end
      cpu_pkg::PUSH_PCL: begin
        il_o.pushed    = 1'b1;
        il_o.push_data = regs_i.pc[7:0];
      end
      cpu_pkg::PUSH_PSR: begin
        il_o.pushed    = 1'b1;
        il_o.push_data = psr_push;
        il_o.set_b     = brk_q;
      end
      cpu_pkg::LOAD_PCL: begin
        il_o.set_i   = 1'b1;
        il_o.set_pcl = 1'b1;
        il_o.data    = handler[7:0];
      end
      cpu_pkg::LOAD_PCH: begin
        il_o.set_pch = 1'b1;
        il_o.data    = handler[15:8];
      end
      default: il_o = '0;
    endcase
  end

  assign busy_o = (state_q != cpu_pkg::IDLE);

endmodule

/* source/stack_port.sv */
/*
 * Stack write port
 * Turns a push strobe into a registered page-one write
 */
`timescale 1ns/10ps
`include "cpu_defines.svh"

module stack_port (
  input  logic              clk,
  input  logic              rst_x,
  input  logic              cen_i,
  input  cpu_pkg::il_cmd_t  il_i,
  input  cpu_pkg::mc_cmd_t  mc_i,
  input  logic [7:0]        sp_i,
  output cpu_pkg::stack_wr_t stack_o
);

  logic        push;
  logic        valid_q;
  logic [15:0] addr_q;
  logic [7:0]  data_q;

  assign push = il_i.pushed | mc_i.pushed;

  always_ff @(posedge clk or negedge rst_x) begin
    if (!rst_x) begin
      valid_q <= 1'b0;
    end else if (cen_i) begin
      valid_q <= push;  // One cen cycle pulse per push
    end
  end

  always_ff @(posedge clk) begin
    if (cen_i && push) begin
      addr_q <= {`STACK_PAGE, sp_i};  // S before the decrement
      // Sequencer wins a collision
      data_q <= il_i.pushed ? il_i.push_data : mc_i.push_data;
    end
  end

  assign stack_o = '{valid: valid_q, addr: addr_q, data: data_q};

endmodule

/* verif/cpu_regs_chk.sv */
/*
 * Bound checks on the CPU register subsystem top
 */
`timescale 1ns/10ps

module cpu_regs_chk (
  input logic               clk,
  input logic               rst_x,
  input logic               cen_i,
  input logic               push_i,
  input cpu_pkg::reg_view_t regs_i,
  input cpu_pkg::stack_wr_t stack_i,
  input logic               irq_busy_i
);

  // Stack write one cen cycle after any push
  stack_follows_push: assert property (
    @(posedge clk) disable iff (!rst_x) (cen_i && push_i) |=> stack_i.valid
  ) else $error("stack write missing after a push strobe");

  no_stack_without_push: assert property (
    @(posedge clk) disable iff (!rst_x) (cen_i && !push_i) |=> !stack_i.valid
  ) else $error("stack write without a push strobe");

  psr_bit5_high: assert property (
    @(posedge clk) disable iff (!rst_x) regs_i.psr[5]
  ) else $error("PSR bit 5 reads zero");

  busy_low_after_reset: assert property (
    @(posedge clk) $rose(rst_x) |-> !irq_busy_i
  ) else $error("interrupt busy high right after reset");

endmodule

bind cpu_regs_top cpu_regs_chk cpu_regs_chk_inst (
  .clk        (clk),
  .rst_x      (rst_x),
  .cen_i      (cen_i),
  .push_i     (il_cmd.pushed | mc_i.pushed),
  .regs_i     (regs_o),
  .stack_i    (stack_o),
  .irq_busy_i (irq_busy_o)
);

/* verif/cpu_regs_tb.sv */
/*
 * CPU register subsystem testbench
 * Table of stimulus rows checked against a cycle reference model
 */
`timescale 1ns/10ps
`include "cpu_defines.svh"

module cpu_regs_tb;

  logic               clk;
  logic               rst_x;
  logic               cen;
  cpu_pkg::ec_cmd_t   ec_cmd;
  cpu_pkg::mc_cmd_t   mc_cmd;
  logic               nmi;
  logic               irq;
  logic               brk;
  cpu_pkg::reg_view_t regs;
  cpu_pkg::stack_wr_t stack;
  logic               irq_busy;

  // Stimulus table
  string            name_q[$];
  cpu_pkg::ec_cmd_t ec_q[$];
  cpu_pkg::mc_cmd_t mc_q[$];
  logic [2:0]       int_q[$];  // nmi, irq, brk
  logic             cen_q[$];
  logic             table_ready;

  // Reference model state
  cpu_pkg::reg_view_t exp_regs;
  cpu_pkg::stack_wr_t exp_stack;
  int                 exp_step;
  logic               exp_nmi;
  logic               exp_brk;
  logic [31:0]        seed;

  cpu_regs_top cpu_regs_top_inst (
    .clk        (clk),
    .rst_x      (rst_x),
    .cen_i      (cen),
    .ec_i       (ec_cmd),
    .mc_i       (mc_cmd),
    .nmi_i      (nmi),
    .irq_i      (irq),
    .brk_i      (brk),
    .regs_o     (regs),
    .stack_o    (stack),
    .irq_busy_o (irq_busy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [7:0] rand_byte();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed[23:16];
  endfunction

  task automatic add_row(input string name, input cpu_pkg::ec_cmd_t e,
                         input cpu_pkg::mc_cmd_t m, input logic [2:0] ints, input logic c);
    name_q.push_back(name);
    ec_q.push_back(e);
    mc_q.push_back(m);
    int_q.push_back(ints);
    cen_q.push_back(c);
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      $display("[ERROR] %s: expected %h actual %h", name, exp, act);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic check_state(input string name);
    check_value({name, " regs"}, exp_regs, regs);
    check_value({name, " busy"}, exp_step != 0, irq_busy);
    check_value({name, " stack valid"}, exp_stack.valid, stack.valid);
    if (exp_stack.valid) begin
      check_value({name, " stack addr"}, exp_stack.addr, stack.addr);
      check_value({name, " stack data"}, exp_stack.data, stack.data);
    end
  endtask

  // One cen cycle of the architectural rules
  task automatic model_step(input cpu_pkg::ec_cmd_t e, input cpu_pkg::mc_cmd_t m,
                            input logic [2:0] ints, input logic c);
    logic        il_push;
    logic [7:0]  il_pd;
    logic        il_seti;
    logic        il_setb;
    logic        il_pcl;
    logic        il_pch;
    logic [15:0] hdl;
    logic [7:0]  p;
    logic        take;
    if (!c) return;
    {il_push, il_pd, il_seti, il_setb, il_pcl, il_pch} = '0;
    hdl = exp_nmi ? `NMI_HANDLER : `IRQ_HANDLER;
    case (exp_step)
      1: {il_push, il_pd} = {1'b1, exp_regs.pc[15:8]};
      2: {il_push, il_pd} = {1'b1, exp_regs.pc[7:0]};
      3: begin
        il_push = 1'b1;
        il_pd = exp_regs.psr;
        il_pd[`PSR_B] = exp_brk;
        il_setb = exp_brk;
      end
      4: {il_seti, il_pcl} = 2'b11;
      5: il_pch = 1'b1;
      default: ;
    endcase
    take = (exp_step == 0) && (ints[2] || ints[0] || (ints[1] && !exp_regs.psr[`PSR_I]));

    exp_stack.valid = il_push | m.pushed;
    if (exp_stack.valid) begin
      exp_stack.addr = {`STACK_PAGE, exp_regs.s};
      exp_stack.data = il_push ? il_pd : m.push_data;
    end

    if (il_pcl || il_pch || e.set_pcl || e.set_pch) begin
      if (il_pcl) exp_regs.pc[7:0] = hdl[7:0];
      else if (e.set_pcl) exp_regs.pc[7:0] = e.data;
      if (il_pch) exp_regs.pc[15:8] = hdl[15:8];
      else if (e.set_pch) exp_regs.pc[15:8] = e.data;
    end else if (m.fetched) begin
      exp_regs.pc = exp_regs.pc + 16'd1;
    end else if (m.set_pc) begin
      exp_regs.pc = m.pc;
    end
    if (e.set_a) exp_regs.a = e.data;
    if (e.set_x) exp_regs.x = e.data;
    if (e.set_y) exp_regs.y = e.data;
    if (e.set_s) exp_regs.s = e.data;
    else if (il_push || m.pushed) exp_regs.s = exp_regs.s - 8'd1;
    else if (m.pull) exp_regs.s = exp_regs.s + 8'd1;

    p = m.set_psr ? m.psr : exp_regs.psr;
    if (il_seti) p[`PSR_I] = 1'b1;
    if (il_setb) p[`PSR_B] = 1'b1;
    if (e.set_c) p[`PSR_C] = e.c;
    if (e.set_z) p[`PSR_Z] = e.z;
    if (e.set_i) p[`PSR_I] = e.i;
    if (e.set_d) p[`PSR_D] = e.d;
    if (e.set_v) p[`PSR_V] = e.v;
    if (e.set_n) p[`PSR_N] = e.n;
    p[5] = 1'b1;
    exp_regs.psr = p;

    if (take) begin
      exp_step = 1;
      exp_nmi  = ints[2];
      exp_brk  = !ints[2] && ints[0];
    end else if (exp_step != 0) begin
      exp_step = (exp_step == `IRQ_STEPS) ? 0 : exp_step + 1;
    end
  endtask

  task automatic add_idle(input string name, input int n);
    for (int k = 0; k < n; k++) begin
      add_row(name, '0, '0, 3'b000, 1'b1);
    end
  endtask

  task automatic build_table();
    cpu_pkg::ec_cmd_t e;
    cpu_pkg::mc_cmd_t m;
    // Register and flag loads
    e = '0;
    e.set_a = 1'b1;
    e.data = rand_byte();
    add_row("load_a", e, '0, 3'b000, 1'b1);
    e = '0;
    e.set_x = 1'b1;
    e.data = rand_byte();
    add_row("load_x", e, '0, 3'b000, 1'b1);
    e = '0;
    e.set_y = 1'b1;
    e.data = rand_byte();
    add_row("load_y", e, '0, 3'b000, 1'b1);
    e = '0;
    e.set_s = 1'b1;
    e.data = 8'hff;
    add_row("load_s", e, '0, 3'b000, 1'b1);
    e = '0;
    {e.set_c, e.c, e.set_n, e.n, e.set_v, e.v} = 6'b111111;
    {e.set_z, e.z, e.set_d, e.d} = 4'b1110;  // D cleared against the PSR load
    m = '0;
    m.set_psr = 1'b1;
    m.psr = 8'h0c;
    add_row("ec_flags_beat_psr", e, m, 3'b000, 1'b1);
    // PC priorities
    e = '0;
    {e.set_pcl, e.set_pch} = 2'b11;
    e.data = 8'hff;
    m = '0;
    m.fetched = 1'b1;
    add_row("ec_pc_beats_fetch", e, m, 3'b000, 1'b1);
    m = '0;
    m.fetched = 1'b1;
    m.set_pc = 1'b1;
    m.pc = 16'h5555;
    add_row("fetch_wraps", '0, m, 3'b000, 1'b1);
    // Stack pointer and mc pushes
    e = '0;
    e.set_s = 1'b1;
    e.data = 8'h80;
    m = '0;
    m.pushed = 1'b1;
    m.push_data = rand_byte();
    add_row("set_s_beats_push", e, m, 3'b000, 1'b1);
    m = '0;
    m.pushed = 1'b1;
    m.pull = 1'b1;
    m.push_data = rand_byte();
    add_row("push_beats_pull", '0, m, 3'b000, 1'b1);
    m = '0;
    m.pull = 1'b1;
    add_row("pull", '0, m, 3'b000, 1'b1);
    // NMI entry from a known PC and PSR
    m = '0;
    m.set_pc = 1'b1;
    m.pc = 16'h1234;
    m.set_psr = 1'b1;
    m.psr = 8'hc3;
    add_row("nmi_setup", '0, m, 3'b000, 1'b1);
    add_row("nmi_accept", '0, '0, 3'b100, 1'b1);
    add_idle("nmi_entry", 6);
    add_row("irq_masked", '0, '0, 3'b010, 1'b1);
    add_idle("irq_masked_idle", 2);
    add_row("brk_accept", '0, '0, 3'b001, 1'b1);
    // mc push collides with the PCH push
    m = '0;
    m.pushed = 1'b1;
    m.push_data = rand_byte();
    add_row("brk_push_collide", '0, m, 3'b000, 1'b1);
    add_idle("brk_entry", 5);
    e = '0;
    e.set_i = 1'b1;
    add_row("clear_i", e, '0, 3'b000, 1'b1);
    add_row("irq_accept", '0, '0, 3'b010, 1'b1);
    add_idle("irq_entry", 6);
    // Frozen by cen
    e = '0;
    {e.set_a, e.set_s, e.set_pcl} = 3'b111;
    e.data = rand_byte();
    m = '0;
    {m.fetched, m.pushed, m.set_psr} = 3'b111;
    add_row("cen_low", e, m, 3'b101, 1'b0);
    add_row("cen_low_again", e, m, 3'b010, 1'b0);
    add_idle("final", 2);
  endtask

  initial begin
    rst_x  = 1'b0;
    cen    = 1'b0;
    ec_cmd = '0;
    mc_cmd = '0;
    nmi    = 1'b0;
    irq    = 1'b0;
    brk    = 1'b0;
    seed   = 32'hfd72_0142;
    table_ready = 1'b0;
    exp_regs  = '0;
    exp_regs.psr = 8'h20;
    exp_stack = '0;
    exp_step  = 0;
    exp_nmi   = 1'b0;
    exp_brk   = 1'b0;
    build_table();
    table_ready = 1'b1;

    repeat (16) @(posedge clk);
    rst_x <= 1'b1;
    @(negedge clk);
    check_state("reset");
    for (int i = 0; i < name_q.size(); i++) begin
      @(posedge clk);
      ec_cmd <= ec_q[i];
      mc_cmd <= mc_q[i];
      {nmi, irq, brk} <= int_q[i];
      cen    <= cen_q[i];
      @(negedge clk);
      check_state((i == 0) ? "reset" : name_q[i - 1]);
      model_step(ec_q[i], mc_q[i], int_q[i], cen_q[i]);
    end
    @(posedge clk);
    ec_cmd <= '0;
    mc_cmd <= '0;
    {nmi, irq, brk} <= 3'b000;
    cen    <= 1'b1;
    @(negedge clk);
    check_state(name_q[name_q.size() - 1]);
    $display("PASS: all tests");
    $finish;
  end

  // Watchdog sized from the table
  initial begin
    wait (table_ready);
    #((name_q.size() * 8 + 64) * 8);
    $display("Timeout: the table did not finish in time");
    $display("FAIL: see errors above");
    $fatal(1);
  end

endmodule

/* verilog.f */
+incdir+common
common/cpu_pkg.sv
regfile/status_reg.sv
regfile/reg_file.sv
source/irq_sequencer.sv
source/stack_port.sv
source/cpu_regs_top.sv
verif/cpu_regs_chk.sv
verif/cpu_regs_tb.sv
